/* tri_assembly.f */
common/tri_pkg.sv
fetch/triangle_fetch.sv
transform/world_transform.sv
src/backface_cull.sv
src/tri_assembly_top.sv
dv/tb_tri_assembly_asserts.sv
dv/tb_tri_assembly.sv

/* Bender.yml */
package:
  name: tri_assembly

sources:
  - common/tri_pkg.sv
  - fetch/triangle_fetch.sv
  - transform/world_transform.sv
  - src/backface_cull.sv
  - src/tri_assembly_top.sv
  - target: simulation
    files:
      - dv/tb_tri_assembly_asserts.sv
      - dv/tb_tri_assembly.sv

/* dv/tri_trace.txt */
# C name idx_base vtx_base count m00..m33 (row-major) | V addr pos.xyzw col.rgba | I addr i0 i1 i2
# R first_addr n_words (enables read checks) | T 24 words v0 v1 v2 (pos then col) | X runs the command
V 1000 00000000 00000000 00000000 00010000 000A0001 000A0002 000A0003 000A0004
V 1020 00020000 00000000 00000000 00010000 000B0001 000B0002 000B0003 000B0004
V 1040 00000000 00020000 00000000 00010000 000C0001 000C0002 000C0003 000C0004
V 1060 00020000 00020000 00010000 00010000 000D0001 000D0002 000D0003 000D0004
C reads 100 1000 1 00010000 0 0 0 0 00010000 0 0 0 0 00010000 0 0 0 0 00010000
I 100 2 0 1
R 100 3
R 1040 8
R 1000 8
R 1020 8
T 00000000 00020000 00000000 00010000 000C0001 000C0002 000C0003 000C0004 00000000 00000000 00000000 00010000 000A0001 000A0002 000A0003 000A0004 00020000 00000000 00000000 00010000 000B0001 000B0002 000B0003 000B0004
X
C translate 200 1000 1 00010000 0 0 00030000 0 00010000 0 FFFF0000 0 0 00010000 0 0 0 0 00010000
I 200 0 1 2
T 00030000 FFFF0000 00000000 00010000 000A0001 000A0002 000A0003 000A0004 00050000 FFFF0000 00000000 00010000 000B0001 000B0002 000B0003 000B0004 00030000 00010000 00000000 00010000 000C0001 000C0002 000C0003 000C0004
X
C scale 300 1000 2 00008000 0 0 0 0 00030000 0 0 0 0 00020000 0 0 0 0 00010000
I 300 0 1 2
I 30C 1 3 2
T 00000000 00000000 00000000 00010000 000A0001 000A0002 000A0003 000A0004 00010000 00000000 00000000 00010000 000B0001 000B0002 000B0003 000B0004 00000000 00060000 00000000 00010000 000C0001 000C0002 000C0003 000C0004
T 00010000 00000000 00000000 00010000 000B0001 000B0002 000B0003 000B0004 00010000 00060000 00020000 00010000 000D0001 000D0002 000D0003 000D0004 00000000 00060000 00000000 00010000 000C0001 000C0002 000C0003 000C0004
X
C cull 400 1000 4 00010000 0 0 0 0 00010000 0 0 0 0 00010000 0 0 0 0 00010000
I 400 0 1 2
I 40C 1 0 2
I 418 0 3 0
I 424 1 3 2
T 00000000 00000000 00000000 00010000 000A0001 000A0002 000A0003 000A0004 00020000 00000000 00000000 00010000 000B0001 000B0002 000B0003 000B0004 00000000 00020000 00000000 00010000 000C0001 000C0002 000C0003 000C0004
T 00020000 00000000 00000000 00010000 000B0001 000B0002 000B0003 000B0004 00020000 00020000 00010000 00010000 000D0001 000D0002 000D0003 000D0004 00000000 00020000 00000000 00010000 000C0001 000C0002 000C0003 000C0004
X
C backpressure 500 1000 3 00010000 0 0 0 0 00010000 0 0 0 0 00010000 0 0 0 0 00010000
I 500 0 1 2
I 50C 2 0 1
I 518 1 3 2
T 00000000 00000000 00000000 00010000 000A0001 000A0002 000A0003 000A0004 00020000 00000000 00000000 00010000 000B0001 000B0002 000B0003 000B0004 00000000 00020000 00000000 00010000 000C0001 000C0002 000C0003 000C0004
T 00000000 00020000 00000000 00010000 000C0001 000C0002 000C0003 000C0004 00000000 00000000 00000000 00010000 000A0001 000A0002 000A0003 000A0004 00020000 00000000 00000000 00010000 000B0001 000B0002 000B0003 000B0004
T 00020000 00000000 00000000 00010000 000B0001 000B0002 000B0003 000B0004 00020000 00020000 00010000 00010000 000D0001 000D0002 000D0003 000D0004 00000000 00020000 00000000 00010000 000C0001 000C0002 000C0003 000C0004
X
C zero 600 1000 0 00010000 0 0 0 0 00010000 0 0 0 0 00010000 0 0 0 0 00010000
R 0 0
X

/* dv/tb_tri_assembly.sv */
`timescale 1ns/1ns

module tb_tri_assembly import tri_pkg::*; ;

    logic      i_clk;
    logic      i_reset_n;
    logic      i_start;
    draw_cmd_t i_cmd;
    logic      o_ready;
    logic      o_mem_read;
    addr_t     o_mem_addr;
    fixed_t    i_mem_data;
    logic      o_tri_valid;
    triangle_t o_tri;
    logic      i_tri_ready;

    logic [31:0]      mem [addr_t];             // sparse memory image
    addr_t            exp_rd [$];
    triangle_t        exp_tri [$];
    bit               check_rd;
    draw_cmd_t        cmd;
    draw_cmd_t        stray;
    reg [8*32-1:0]    cur_name;
    int               seed = 54;
    int               cycles = 0;
    int               limit = 1000000;          // replaced after the trace scan
    int               tests = 0;
    int               errors = 0;
    int               test_errs = 0;
    logic             rd_now;
    addr_t            rd_addr;
    addr_t            exp_a;
    triangle_t        exp_t;

    tri_assembly_top dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory and rasterizer models
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge i_clk) begin
        rd_now  = o_mem_read;
        rd_addr = o_mem_addr;
        #1;
        if (rd_now)
            i_mem_data <= mem.exists(rd_addr) ? mem[rd_addr] : ~rd_addr;
    end

    initial begin
        forever begin
            @(posedge i_clk);
            #1 i_tri_ready = ($unsigned($random(seed)) % 3) != 0;   // low about 1/3
        end
    end

    // read order and triangle checks, sampled on the edge
    always @(posedge i_clk) begin
        if (i_reset_n && o_mem_read && check_rd) begin
            assert (exp_rd.size() != 0) else begin
                $display("%0s: unexpected read at address %h", cur_name, o_mem_addr);
                test_errs++;
            end
            if (exp_rd.size() != 0) begin
                exp_a = exp_rd.pop_front();
                assert (o_mem_addr == exp_a) else begin
                    $display("** Error %0s: read address expected %h actual %h",
                             cur_name, exp_a, o_mem_addr);
                    test_errs++;
                end
            end
        end
        if (i_reset_n && o_tri_valid && i_tri_ready) begin
            assert (exp_tri.size() != 0) else begin
                $display("%0s: unexpected triangle %h", cur_name, o_tri);
                test_errs++;
            end
            if (exp_tri.size() != 0) begin
                exp_t = exp_tri.pop_front();
                assert (o_tri == exp_t) else begin
                    $display("** Error %0s: triangle expected %h actual %h",
                             cur_name, exp_t, o_tri);
                    test_errs++;
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // one command from start to o_ready
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_test;
        tests++;
        @(posedge i_clk);
        #1;
        assert (o_ready) else begin
            $display("%0s: o_ready was low before start", cur_name);
            test_errs++;
        end
        i_cmd   = cmd;
        i_start = 1'b1;
        @(posedge i_clk);
        #1;
        i_start = 1'b0;
        assert (!o_ready) else begin
            $display("%0s: o_ready stayed high after start", cur_name);
            test_errs++;
        end
        // a start held through every busy cycle must be ignored
        stray           = cmd;
        stray.idx_base  = 32'h0000_fff0;
        stray.tri_count = 32'd7;
        while (!o_ready) begin
            i_cmd   = stray;
            i_start = 1'b1;
            @(posedge i_clk);
            #1;
        end
        i_start = 1'b0;
        i_cmd   = cmd;
        assert (exp_rd.size() == 0 && exp_tri.size() == 0) else begin
            $display("%0s: command ended with %0d reads and %0d triangles missing",
                     cur_name, exp_rd.size(), exp_tri.size());
            test_errs++;
        end
        $display("test %0s: %0s, %0d errors", cur_name,
                 (test_errs == 0) ? "ok" : "failed", test_errs);
        errors += test_errs;
    endtask

    initial begin
        int            fd;
        int            code;
        int            n;
        int            ncmd;
        int            ntri;
        reg [7:0]      ch;
        reg [8*256-1:0] skip;
        reg [8*32-1:0] name;
        logic [31:0]   a;
        logic [31:0]   w;
        logic [511:0]  mbits;
        logic [767:0]  tbits;

        i_reset_n  = 1'b0;
        i_start    = 1'b0;
        i_cmd      = '0;
        i_mem_data = '0;
        i_tri_ready = 1'b0;
        check_rd   = 1'b0;
        ncmd       = 0;
        ntri       = 0;

        // first pass sizes the timeout
        fd = $fopen("dv/tri_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file");
            $display("Done: errors found");
            $finish;
        end else begin
            while ($fscanf(fd, " %c", ch) == 1) begin
                if (ch == "C")
                    ncmd++;
                if (ch == "T")
                    ntri++;
                code = $fgets(skip, fd);
            end
            $fclose(fd);
            limit = 200 * ntri + 100 * ncmd;

            repeat (10) @(posedge i_clk);
            #1 i_reset_n = 1'b1;

            fd = $fopen("dv/tri_trace.txt", "r");
            while ($fscanf(fd, " %c", ch) == 1) begin
                case (ch)
                    "C": begin
                        code = $fscanf(fd, " %s %h %h %h", name, cmd.idx_base,
                                       cmd.vtx_base, cmd.tri_count);
                        for (int k = 0; k < 16; k++) begin
                            code  = $fscanf(fd, " %h", w);
                            mbits = {mbits[479:0], w};      // row-major, row 0 on top
                        end
                        cmd.world = mat44_t'(mbits);
                        cur_name  = name;
                        test_errs = 0;
                        check_rd  = 1'b0;
                        exp_rd.delete();
                        exp_tri.delete();
                    end
                    "V": begin
                        code = $fscanf(fd, " %h", a);
                        for (int k = 0; k < 8; k++) begin
                            code = $fscanf(fd, " %h", w);
                            mem[a + 4 * k] = w;
                        end
                    end
                    "I": begin
                        code = $fscanf(fd, " %h", a);
                        for (int k = 0; k < 3; k++) begin
                            code = $fscanf(fd, " %h", w);
                            mem[a + 4 * k] = w;
                        end
                    end
                    "R": begin
                        code     = $fscanf(fd, " %h %d", a, n);
                        check_rd = 1'b1;
                        for (int k = 0; k < n; k++)
                            exp_rd.push_back(a + 4 * k);
                    end
                    "T": begin
                        for (int k = 0; k < 24; k++) begin
                            code  = $fscanf(fd, " %h", w);
                            tbits = {tbits[735:0], w};
                        end
                        exp_tri.push_back(triangle_t'(tbits));
                    end
                    "X": run_test();
                    "#": code = $fgets(skip, fd);
                    default: begin
                        $display("Trace line with unknown tag %c", ch);
                        errors++;
                        code = $fgets(skip, fd);
                    end
                endcase
            end
            $fclose(fd);

            errors += dut.u_asserts.fail_count;
            $display("%0d tests, %0d errors", tests, errors);
            if (errors == 0)
                $display("Done: no errors");
            else
                $display("Done: errors found");
            $finish;
        end
    end

endmodule

/* dv/tb_tri_assembly_asserts.sv */
`timescale 1ns/1ns

module tb_tri_assembly_asserts import tri_pkg::*; (
    input logic      i_clk,
    input logic      i_reset_n,
    input logic      i_start,
    input logic      o_ready,
    input logic      o_mem_read,
    input logic      o_tri_valid,
    input triangle_t o_tri,
    input logic      i_tri_ready
);

    int fail_count = 0;                         // failed assertions so far

    // output triangle must hold while the rasterizer stalls
    assert property (@(posedge i_clk) disable iff (!i_reset_n)
                     o_tri_valid && !i_tri_ready |=> $stable(o_tri))
        else begin
            $error("o_tri changed while stalled");
            fail_count++;
        end

    assert property (@(posedge i_clk) !i_reset_n |-> !o_mem_read && !o_tri_valid)
        else begin
            $error("read or triangle valid during reset");
            fail_count++;
        end

    // an accepted start drops o_ready on the next cycle
    assert property (@(posedge i_clk) disable iff (!i_reset_n)
                     o_ready && i_start |=> !o_ready)
        else begin
            $error("o_ready still high after an accepted start");
            fail_count++;
        end

endmodule

bind tri_assembly_top tb_tri_assembly_asserts u_asserts (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_start     (i_start),
    .o_ready     (o_ready),
    .o_mem_read  (o_mem_read),
    .o_tri_valid (o_tri_valid),
    .o_tri       (o_tri),
    .i_tri_ready (i_tri_ready)
);

/* src/tri_assembly_top.sv */
`timescale 1ns/1ns

module tri_assembly_top import tri_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset_n,

    input  logic      i_start,
    input  draw_cmd_t i_cmd,
    output logic      o_ready,

    output logic      o_mem_read,
    output addr_t     o_mem_addr,
    input  fixed_t    i_mem_data,

    output logic      o_tri_valid,
    output triangle_t o_tri,
    input  logic      i_tri_ready
);

    logic      start_ok;        // start seen only while the whole pipe is idle
    logic      fetch_ready;
    logic      fetch_busy;
    mat44_t    world;

    logic      f2x_valid;       // fetch to transform
    logic      f2x_ready;
    triangle_t f2x_tri;

    logic      x2c_valid;       // transform to cull
    logic      x2c_ready;
    triangle_t x2c_tri;
    logic      xform_busy;

    logic      pipe_idle;

    triangle_fetch u_fetch (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_start     (start_ok),
        .i_cmd       (i_cmd),
        .o_ready_cmd (fetch_ready),
        .o_busy      (fetch_busy),
        .o_mem_read  (o_mem_read),
        .o_mem_addr  (o_mem_addr),
        .i_mem_data  (i_mem_data),
        .o_world     (world),
        .o_tri_valid (f2x_valid),
        .o_tri       (f2x_tri),
        .i_tri_ready (f2x_ready)
    );

    world_transform u_xform (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_world     (world),
        .i_tri_valid (f2x_valid),
        .i_tri       (f2x_tri),
        .o_tri_ready (f2x_ready),
        .o_tri_valid (x2c_valid),
        .o_tri       (x2c_tri),
        .i_tri_ready (x2c_ready),
        .o_busy      (xform_busy)
    );

    backface_cull u_cull (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_tri_valid (x2c_valid),
        .i_tri       (x2c_tri),
        .o_tri_ready (x2c_ready),
        .o_tri_valid (o_tri_valid),
        .o_tri       (o_tri),
        .i_tri_ready (i_tri_ready)
    );

    // nothing left in flight once all three stages are empty
    assign pipe_idle = !fetch_busy && !xform_busy && !o_tri_valid;
    assign o_ready   = fetch_ready && pipe_idle;
    assign start_ok  = i_start && o_ready;

endmodule

/* src/backface_cull.sv */
`timescale 1ns/1ns

module backface_cull import tri_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset_n,

    input  logic      i_tri_valid,
    input  triangle_t i_tri,
    output logic      o_tri_ready,

    output logic      o_tri_valid,
    output triangle_t o_tri,
    input  logic      i_tri_ready
);

    logic              r_valid;
    triangle_t         r_tri;

    logic signed [32:0] dx21, dy21;             // one bit of headroom on differences
    logic signed [32:0] dx31, dy31;
    logic signed [66:0] area;                   // twice the signed area
    logic              front;
    logic              accept;

    ////////////////////////////////////////////////////////////////////////////
    // signed area on world x and y
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        dx21 = $signed(i_tri.v[1].pos.x) - $signed(i_tri.v[0].pos.x);
        dy21 = $signed(i_tri.v[1].pos.y) - $signed(i_tri.v[0].pos.y);
        dx31 = $signed(i_tri.v[2].pos.x) - $signed(i_tri.v[0].pos.x);
        dy31 = $signed(i_tri.v[2].pos.y) - $signed(i_tri.v[0].pos.y);
        area = dx21 * dy31 - dx31 * dy21;
    end

    assign front       = (area > 0);            // zero area counts as culled
    assign o_tri_ready = !r_valid || i_tri_ready;
    assign accept      = i_tri_valid && o_tri_ready;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_valid <= 1'b0;
        end else begin
            if (r_valid && i_tri_ready)
                r_valid <= 1'b0;
            if (accept && front)
                r_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept && front)
            r_tri <= i_tri;
    end

    assign o_tri_valid = r_valid;
    assign o_tri       = r_tri;

endmodule

/* transform/world_transform.sv */
`timescale 1ns/1ns

module world_transform import tri_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset_n,

    input  mat44_t    i_world,

    input  logic      i_tri_valid,
    input  triangle_t i_tri,
    output logic      o_tri_ready,

    output logic      o_tri_valid,
    output triangle_t o_tri,
    input  logic      i_tri_ready,

    output logic      o_busy
);

    logic              r_busy;                  // triangle held until hand-off
    logic              r_valid;
    logic [1:0]        r_phase;                 // 1..3 while the pipeline runs

    triangle_t         r_in;                    // colours come straight from here
    logic signed [63:0] r_prod [0:3][0:3];      // stage one products
    vec4_t             r_pos [0:VERTS_PER_TRI-1];

    logic              accept;
    logic              s1_load;
    vec4_t             feed_pos;
    fixed_t [0:3]      feed_c;
    fixed_t [0:3][0:3] mat_c;
    fixed_t [0:3]      sum_c;

    assign accept  = i_tri_valid && !r_busy;
    assign s1_load = accept || (r_phase == 2'd1) || (r_phase == 2'd2);
    assign mat_c   = i_world;

    // vertex 0 goes straight in on acceptance, saving a cycle
    always_comb begin
        case (r_phase)
            2'd1:    feed_pos = r_in.v[1].pos;
            2'd2:    feed_pos = r_in.v[2].pos;
            default: feed_pos = i_tri.v[0].pos;
        endcase
    end

    assign feed_c = feed_pos;

    // stage two, row sums back to Q16.16
    always_comb begin
        logic signed [63:0] row_sum;
        for (int i = 0; i < 4; i++) begin
            row_sum  = r_prod[i][0] + r_prod[i][1] + r_prod[i][2] + r_prod[i][3];
            sum_c[i] = fixed_t'(row_sum >>> FRAC_BITS);
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_busy  <= 1'b0;
            r_valid <= 1'b0;
            r_phase <= 2'd0;
        end else begin
            if (accept) begin
                r_busy  <= 1'b1;
                r_phase <= 2'd1;
            end else if (r_phase != 2'd0) begin
                r_phase <= (r_phase == 2'd3) ? 2'd0 : r_phase + 2'd1;
                if (r_phase == 2'd3)
                    r_valid <= 1'b1;            // last vertex lands this edge
            end

            if (r_valid && i_tri_ready) begin
                r_valid <= 1'b0;
                r_busy  <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept)
            r_in <= i_tri;
        if (s1_load) begin
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    r_prod[i][j] <= $signed(mat_c[i][j]) * $signed(feed_c[j]);
        end
        if (r_phase != 2'd0)
            r_pos[r_phase - 2'd1] <= sum_c;
    end

    always_comb begin
        o_tri = r_in;
        for (int k = 0; k < VERTS_PER_TRI; k++)
            o_tri.v[k].pos = r_pos[k];
    end

    assign o_tri_ready = !r_busy;
    assign o_tri_valid = r_valid;
    assign o_busy      = r_busy;

endmodule

/* fetch/triangle_fetch.sv */
`timescale 1ns/1ns

module triangle_fetch import tri_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset_n,

    input  logic      i_start,
    input  draw_cmd_t i_cmd,
    output logic      o_ready_cmd,
    output logic      o_busy,

    output logic      o_mem_read,
    output addr_t     o_mem_addr,
    input  fixed_t    i_mem_data,

    output mat44_t    o_world,
    output logic      o_tri_valid,
    output triangle_t o_tri,
    input  logic      i_tri_ready
);

    fetch_state_t r_state;
    draw_cmd_t    r_cmd;
    logic [31:0]  r_tri_idx;                    // triangles handed off so far
    logic [4:0]   r_word;                       // read slot within the triangle

    addr_t        r_index [0:VERTS_PER_TRI-1];
    fixed_t [0:VERTS_PER_TRI*VERTEX_STRIDE_WORDS-1] r_vwords;

    logic [4:0]   words_per_tri;                // 3 index words plus 24 vertex words
    logic [4:0]   rd_vword;                     // vertex word being requested
    logic [4:0]   cap_word;                     // word arriving from memory
    logic [4:0]   cap_vword;
    logic         cap_en;
    addr_t        rec_off;                      // word offset inside a vertex record

    assign words_per_tri = 5'(VERTS_PER_TRI * (VERTEX_STRIDE_WORDS + 1));
    assign rd_vword      = r_word - 5'(VERTS_PER_TRI);
    assign cap_word      = r_word - 5'd1;       // data lags the read by one cycle
    assign cap_vword     = cap_word - 5'(VERTS_PER_TRI);

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_state   <= IDLE;
            r_tri_idx <= '0;
            r_word    <= '0;
        end else begin
            case (r_state)
                IDLE: begin
                    if (i_start) begin
                        r_tri_idx <= '0;
                        r_word    <= '0;
                        // empty command skips straight to the end check
                        r_state   <= (i_cmd.tri_count == '0) ? NEXT_TRI : LOAD_INDEX;
                    end
                end
                LOAD_INDEX: begin
                    r_word <= r_word + 5'd1;
                    if (r_word == 5'(VERTS_PER_TRI - 1))
                        r_state <= LOAD_VERTEX;
                end
                LOAD_VERTEX: begin
                    r_word <= r_word + 5'd1;
                    if (r_word == words_per_tri)    // last word captured
                        r_state <= HAND_OFF;
                end
                HAND_OFF: begin
                    if (i_tri_ready) begin
                        r_tri_idx <= r_tri_idx + 32'd1;
                        r_state   <= NEXT_TRI;
                    end
                end
                NEXT_TRI: begin
                    r_word  <= '0;
                    r_state <= (r_tri_idx == r_cmd.tri_count) ? IDLE : LOAD_INDEX;
                end
                default: r_state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read address generation
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rec_off = addr_t'(rd_vword[1:0]);
        if (rd_vword[2])
            rec_off = rec_off + COLOUR_OFFSET_WORDS;   // second half is colour

        o_mem_read = 1'b0;
        o_mem_addr = '0;
        case (r_state)
            LOAD_INDEX: begin
                o_mem_read = 1'b1;
                o_mem_addr = r_cmd.idx_base
                           + addr_t'((r_tri_idx * VERTS_PER_TRI + r_word) * WORD_BYTES);
            end
            LOAD_VERTEX: begin
                if (r_word < words_per_tri) begin
                    o_mem_read = 1'b1;
                    o_mem_addr = r_cmd.vtx_base
                               + addr_t'((r_index[rd_vword[4:3]] * VERTEX_STRIDE_WORDS
                                          + rec_off) * WORD_BYTES);
                end
            end
            default: begin
                o_mem_read = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // command and triangle registers
    ////////////////////////////////////////////////////////////////////////////

    assign cap_en = ((r_state == LOAD_INDEX) && (r_word != '0)) || (r_state == LOAD_VERTEX);

    always_ff @(posedge i_clk) begin
        if ((r_state == IDLE) && i_start)
            r_cmd <= i_cmd;

        if (cap_en) begin
            if (cap_word < 5'(VERTS_PER_TRI))
                r_index[cap_word[1:0]] <= addr_t'(i_mem_data);
            else
                r_vwords[cap_vword] <= i_mem_data;  // pos then colour per vertex
        end
    end

    assign o_ready_cmd = (r_state == IDLE);
    assign o_busy      = (r_state != IDLE);
    assign o_world     = r_cmd.world;
    assign o_tri_valid = (r_state == HAND_OFF);
    assign o_tri       = triangle_t'(r_vwords); // word order matches triangle_t

endmodule

/* common/tri_pkg.sv */
package tri_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // layout constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W              = 32;    // address and memory data width
    localparam int FRAC_BITS           = 16;    // fraction bits of fixed_t
    localparam int WORD_BYTES          = 4;
    localparam int VERTS_PER_TRI       = 3;
    localparam int VERTEX_STRIDE_WORDS = 8;     // position then colour
    localparam int COLOUR_OFFSET_WORDS = 4;

    ////////////////////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0] addr_t;          // byte address

    typedef logic signed [31:0] fixed_t;        // Q16.16

    // x, y, z, w for positions, r, g, b, a for colours
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
        fixed_t w;
    } vec4_t;

    typedef struct packed {
        vec4_t [0:3] row;                       // row 0 in the top bits
    } mat44_t;

    typedef struct packed {
        vec4_t pos;
        vec4_t col;
    } vertex_t;

    typedef struct packed {
        vertex_t [0:VERTS_PER_TRI-1] v;         // index order
    } triangle_t;

    typedef struct packed {
        addr_t       idx_base;                  // index buffer, one word per index
        addr_t       vtx_base;                  // vertex buffer
        logic [31:0] tri_count;
        mat44_t      world;
    } draw_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_INDEX,
        LOAD_VERTEX,
        HAND_OFF,
        NEXT_TRI
    } fetch_state_t;

endpackage
